// ==== erx_pkg.sv ====
`default_nettype none

package erx_pkg;

   // Transaction packet, field order matches the link format (spare is bit 0)
   typedef struct packed {
      logic [31:0] srcaddr;   // 103:72
      logic [31:0] data;      // 71:40
      logic [31:0] dstaddr;   // 39:8
      logic [3:0]  ctrlmode;  // 7:4
      logic [1:0]  datamode;  // 3:2
      logic        write;     // 1
      logic        spare;     // 0
   } packet_t;

   // Register regions, decoded from mi_addr[11:8]
   typedef enum logic [3:0] {
      REG_CFG = 4'd0,
      REG_DMA = 4'd1,
      REG_MMU = 4'd2
   } region_t;

   typedef enum logic {DEC_IDLE, DEC_BEAT1} dec_state_t;
   typedef enum logic {DMA_IDLE, DMA_RUN} dma_state_t;

   // Register map
   localparam logic [19:0] CFG_ADDR       = 20'h00000;  // Bit 0 rx_enable, bit 1 mmu_enable
   localparam logic [19:0] DMA_DST_ADDR   = 20'h00100;
   localparam logic [19:0] DMA_DATA_ADDR  = 20'h00104;
   localparam logic [19:0] DMA_COUNT_ADDR = 20'h00108;  // Write starts a burst
   localparam logic [19:0] MMU_BASE_ADDR  = 20'h00200;  // Entry i at base + 4*i

   localparam logic [1:0]  DM_WORD = 2'b10;             // 32-bit datamode

   // Translation table
   localparam int MMU_ENTRIES = 16;
   localparam int MMU_AW      = $clog2(MMU_ENTRIES);    // Index from dstaddr[31:28]
   localparam int MMU_TAG_W   = 12;                     // Replaces dstaddr[31:20]

   localparam logic [11:0] RESP_ID = 12'h810;           // Read response tag

   // Receive queues
   localparam int FIFO_DEPTH      = 16;
   localparam int FIFO_AW         = $clog2(FIFO_DEPTH);
   localparam int FIFO_WAIT_LEVEL = 12;                 // Slack for in-flight packets

   function automatic region_t region_of(input logic [19:0] addr);
      return region_t'(addr[11:8]);
   endfunction

endpackage

`default_nettype wire

// ==== erx_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Register bus shared by the config, MMU and DMA blocks
interface mi_if;

   logic        en;     // Access strobe
   logic        we;     // Write when high, read when low
   logic [19:0] addr;
   logic [31:0] din;

   // Top level drives the bus
   modport master (
      output en,
      output we,
      output addr,
      output din
   );

   // Register blocks decode their own region
   modport slave (
      input en,
      input we,
      input addr,
      input din
   );

endinterface

`default_nettype wire

// ==== erx_cfg.sv ====
`timescale 1ns/1ps
`default_nettype none

module erx_cfg
   import erx_pkg::*;
(
   input  logic        rx_lclk_div4,
   input  logic        reset,
   mi_if.slave         mi,
   input  logic [31:0] mmu_dout,
   input  logic [31:0] dma_dout,
   output logic [31:0] mi_dout,
   output logic        rx_enable,
   output logic        mmu_enable
);

   logic [1:0]  cfg_q;        // {mmu_enable, rx_enable}
   logic [31:0] cfg_dout_q;   // Config readback word
   region_t     rd_region_q;  // Region of the pending read
   logic        cfg_wr;
   logic        mi_rd;

   assign cfg_wr = mi.en && mi.we && (mi.addr == CFG_ADDR);
   assign mi_rd  = mi.en && !mi.we;

   assign rx_enable  = cfg_q[0];
   assign mmu_enable = cfg_q[1];

   always_ff @(posedge rx_lclk_div4)
   begin
      if (reset)
         cfg_q <= 2'b00;          // Link and translation off
      else if (cfg_wr)
         cfg_q <= mi.din[1:0];
   end

   // Remember who answers the read
   always_ff @(posedge rx_lclk_div4)
   begin
      if (reset)
         rd_region_q <= REG_CFG;
      else if (mi_rd)
         rd_region_q <= region_of(mi.addr);
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (mi_rd)
         cfg_dout_q <= {30'd0, cfg_q};
   end

   // Read data mux, all sources already registered
   always_comb
   begin
      case (rd_region_q)
         REG_CFG: mi_dout = cfg_dout_q;
         REG_DMA: mi_dout = dma_dout;
         REG_MMU: mi_dout = mmu_dout;
         default: mi_dout = 32'd0;   // Unmapped region
      endcase
   end

endmodule

`default_nettype wire

// ==== erx_protocol.sv ====
`timescale 1ns/1ps
`default_nettype none

// Two-beat frame decoder
// Beat 0: [63:60] ctrlmode, [59:58] datamode, [57] write, [55:24] dstaddr
// Beat 1: [63:32] data, [31:0] srcaddr
module erx_protocol
   import erx_pkg::*;
(
   input  logic        rx_lclk_div4,
   input  logic        reset,
   input  logic        rx_enable,
   input  logic [7:0]  rx_frame_par,
   input  logic [63:0] rx_data_par,
   output logic        erx_access,
   output packet_t     erx_packet
);

   dec_state_t state_q;
   logic       frame_on;   // Frame word all ones
   logic       beat0;
   logic       beat1;

   assign frame_on = (rx_frame_par == 8'hff);
   assign beat0    = rx_enable && frame_on && (state_q == DEC_IDLE);
   assign beat1    = rx_enable && frame_on && (state_q == DEC_BEAT1);

   always_ff @(posedge rx_lclk_div4)
   begin
      if (reset)
      begin
         state_q    <= DEC_IDLE;
         erx_access <= 1'b0;
      end
      else
      begin
         erx_access <= beat1;          // One-cycle strobe after second beat
         case (state_q)
            DEC_IDLE:
               if (beat0)
                  state_q <= DEC_BEAT1;
            default:
               state_q <= DEC_IDLE;    // Done or broken frame
         endcase
      end
   end

   // Packet assembly
   always_ff @(posedge rx_lclk_div4)
   begin
      if (beat0)
      begin
         erx_packet.ctrlmode <= rx_data_par[63:60];
         erx_packet.datamode <= rx_data_par[59:58];
         erx_packet.write    <= rx_data_par[57];
         erx_packet.spare    <= 1'b0;
         erx_packet.dstaddr  <= rx_data_par[55:24];
      end
      if (beat1)
      begin
         erx_packet.data    <= rx_data_par[63:32];
         erx_packet.srcaddr <= rx_data_par[31:0];
      end
   end

   // Link only sends whole frame words
   frame_word_legal: assert property (@(posedge rx_lclk_div4) disable iff (reset)
      frame_on || (rx_frame_par == 8'h00))
      else $error("erx_protocol: partial frame word %h", rx_frame_par);

endmodule

`default_nettype wire

// ==== erx_mmu.sv ====
`timescale 1ns/1ps
`default_nettype none

module erx_mmu
   import erx_pkg::*;
(
   input  logic        rx_lclk_div4,
   input  logic        reset,
   input  logic        mmu_enable,
   mi_if.slave         mi,
   input  logic        in_access,
   input  packet_t     in_packet,
   output logic        out_access,
   output packet_t     out_packet,
   output logic [31:0] mi_dout
);

   logic [MMU_TAG_W-1:0] tag_tbl [MMU_ENTRIES];  // Upper address per region
   logic [MMU_AW-1:0]    mi_idx;
   logic                 mmu_sel;                // Bus hits the table window
   packet_t              remap;

   assign mi_idx  = mi.addr[2 +: MMU_AW];        // Word addressed entries
   assign mmu_sel = (region_of(mi.addr) == REG_MMU) &&
                    (mi.addr[7:6] == MMU_BASE_ADDR[7:6]);

   always_ff @(posedge rx_lclk_div4)
   begin
      if (reset)
      begin
         for (int i = 0; i < MMU_ENTRIES; i++)
            tag_tbl[i] <= '0;
      end
      else if (mi.en && mi.we && mmu_sel)
         tag_tbl[mi_idx] <= mi.din[MMU_TAG_W-1:0];
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (mi.en && !mi.we)
         mi_dout <= {{(32 - MMU_TAG_W){1'b0}}, tag_tbl[mi_idx]};
   end

   // Swap in the table entry picked by the top address nibble
   always_comb
   begin
      remap = in_packet;
      if (mmu_enable)
         remap.dstaddr[31 -: MMU_TAG_W] = tag_tbl[in_packet.dstaddr[31 -: MMU_AW]];
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (reset)
         out_access <= 1'b0;
      else
         out_access <= in_access;
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      out_packet <= remap;   // Payload, qualified by out_access
   end

endmodule

`default_nettype wire

// ==== erx_dma.sv ====
`timescale 1ns/1ps
`default_nettype none

// Local write generator, one word packet per accepted cycle
module erx_dma
   import erx_pkg::*;
(
   input  logic        rx_lclk_div4,
   input  logic        reset,
   mi_if.slave         mi,
   input  logic        dma_wait,
   output logic        dma_access,
   output packet_t     dma_packet,
   output logic [31:0] mi_dout
);

   dma_state_t  state_q;
   logic [31:0] dst_q;     // Next destination
   logic [31:0] data_q;    // Next data word
   logic [31:0] count_q;   // Packets left
   logic        mi_wr;
   logic        take;      // Packet accepted this cycle

   assign mi_wr      = mi.en && mi.we && (region_of(mi.addr) == REG_DMA);
   assign dma_access = (state_q == DMA_RUN);
   assign take       = dma_access && !dma_wait;

   always_comb
   begin
      dma_packet          = '0;       // srcaddr, ctrlmode, spare zero
      dma_packet.write    = 1'b1;
      dma_packet.datamode = DM_WORD;
      dma_packet.dstaddr  = dst_q;
      dma_packet.data     = data_q;
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (reset)
      begin
         state_q <= DMA_IDLE;
         count_q <= 32'd0;
      end
      else if (mi_wr && (mi.addr == DMA_COUNT_ADDR))
      begin
         count_q <= mi.din;   // New burst, restarts a running one
         state_q <= (mi.din != 32'd0) ? DMA_RUN : DMA_IDLE;
      end
      else if (take)
      begin
         count_q <= count_q - 32'd1;
         if (count_q == 32'd1)
            state_q <= DMA_IDLE;   // Last one gone
      end
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (mi_wr && (mi.addr == DMA_DST_ADDR))
         dst_q <= mi.din;
      else if (take)
         dst_q <= dst_q + 32'd4;   // Next word address
      if (mi_wr && (mi.addr == DMA_DATA_ADDR))
         data_q <= mi.din;
      else if (take)
         data_q <= data_q + 32'd1;
   end

   // Readback is the remaining count
   always_ff @(posedge rx_lclk_div4)
   begin
      if (mi.en && !mi.we)
         mi_dout <= count_q;
   end

endmodule

`default_nettype wire

// ==== erx_disty.sv ====
`timescale 1ns/1ps
`default_nettype none

module erx_disty
   import erx_pkg::*;
(
   input  logic    rx_lclk_div4,
   input  logic    reset,
   input  logic    emmu_access,
   input  packet_t emmu_packet,
   input  logic    dma_access,
   input  packet_t dma_packet,
   input  logic    wr_fifo_wait,
   input  logic    rd_fifo_wait,
   input  logic    rr_fifo_wait,
   output logic    dma_wait,
   output logic    rxwr_fifo_access,
   output logic    rxrd_fifo_access,
   output logic    rxrr_fifo_access,
   output packet_t fifo_packet,
   output logic    rx_wr_wait,
   output logic    rx_rd_wait
);

   logic    sel_access;  // Something wins the path this cycle
   packet_t sel_packet;
   logic    is_resp;     // Write carrying the response tag

   // Link can't stall, so it always wins
   assign dma_wait   = emmu_access || wr_fifo_wait || rr_fifo_wait;
   assign sel_access = emmu_access || (dma_access && !dma_wait);
   assign sel_packet = emmu_access ? emmu_packet : dma_packet;
   assign is_resp    = sel_packet.write && (sel_packet.dstaddr[31:20] == RESP_ID);

   // Back-pressure to the far end of the link
   assign rx_wr_wait = wr_fifo_wait || rr_fifo_wait;
   assign rx_rd_wait = rd_fifo_wait;

   always_ff @(posedge rx_lclk_div4)
   begin
      if (reset)
      begin
         rxwr_fifo_access <= 1'b0;
         rxrd_fifo_access <= 1'b0;
         rxrr_fifo_access <= 1'b0;
      end
      else
      begin
         rxwr_fifo_access <= sel_access && sel_packet.write && !is_resp;
         rxrd_fifo_access <= sel_access && !sel_packet.write;   // Read request
         rxrr_fifo_access <= sel_access && is_resp;
      end
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      fifo_packet <= sel_packet;   // Shared by all three queues
   end

   queue_strobe_onehot: assert property (@(posedge rx_lclk_div4) disable iff (reset)
      $onehot0({rxwr_fifo_access, rxrd_fifo_access, rxrr_fifo_access}))
      else $error("erx_disty: packet routed to more than one queue");

endmodule

`default_nettype wire

// ==== erx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

// First-word-fall-through queue, head visible while access is high
module erx_fifo
   import erx_pkg::*;
(
   input  logic    rx_lclk_div4,
   input  logic    reset,
   input  logic    wr_en,
   input  packet_t din,
   input  logic    rd_wait,
   output logic    access,
   output packet_t dout,
   output logic    prog_full
);

   packet_t            mem_q [FIFO_DEPTH];
   logic [FIFO_AW-1:0] wr_ptr_q;
   logic [FIFO_AW-1:0] rd_ptr_q;
   logic [FIFO_AW:0]   count_q;    // Occupancy
   logic               full;
   logic               push;
   logic               pop;

   assign full      = (count_q == (FIFO_AW + 1)'(FIFO_DEPTH));
   assign access    = (count_q != '0);
   assign dout      = mem_q[rd_ptr_q];
   assign push      = wr_en && !full;
   assign pop       = access && !rd_wait;
   assign prog_full = (count_q >= (FIFO_AW + 1)'(FIFO_WAIT_LEVEL));

   always_ff @(posedge rx_lclk_div4)
   begin
      if (reset)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= wr_ptr_q + 1'b1;   // Wraps, depth is a power of two
         if (pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         count_q <= count_q + (FIFO_AW + 1)'(push) - (FIFO_AW + 1)'(pop);
      end
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (push)
         mem_q[wr_ptr_q] <= din;
   end

   // Wait level must leave room for the packets still in the pipeline
   no_write_when_full: assert property (@(posedge rx_lclk_div4) disable iff (reset)
      wr_en |-> !full)
      else $error("erx_fifo: write into full queue, packet dropped");

endmodule

`default_nettype wire

// ==== erx.sv ====
`timescale 1ns/1ps
`default_nettype none

module erx
   import erx_pkg::*;
(
   input  logic         rx_lclk_div4,
   input  logic         reset,
   input  logic [7:0]   rx_frame_par,
   input  logic [63:0]  rx_data_par,
   output logic         rx_wr_wait,
   output logic         rx_rd_wait,
   output logic         rxwr_access,
   output logic [103:0] rxwr_packet,
   input  logic         rxwr_wait,
   output logic         rxrd_access,
   output logic [103:0] rxrd_packet,
   input  logic         rxrd_wait,
   output logic         rxrr_access,
   output logic [103:0] rxrr_packet,
   input  logic         rxrr_wait,
   input  logic         mi_en,
   input  logic         mi_we,
   input  logic [19:0]  mi_addr,
   input  logic [31:0]  mi_din,
   output logic [31:0]  mi_dout
);

   logic        rx_enable, mmu_enable;
   logic [31:0] mmu_dout, dma_dout;
   logic        erx_access, emmu_access, dma_access, dma_wait;
   packet_t     erx_packet, emmu_packet, dma_packet, fifo_packet;
   logic        rxwr_fifo_access, rxrd_fifo_access, rxrr_fifo_access;
   logic        wr_fifo_wait, rd_fifo_wait, rr_fifo_wait;

   mi_if mi ();

   assign mi.en   = mi_en;
   assign mi.we   = mi_we;
   assign mi.addr = mi_addr;
   assign mi.din  = mi_din;

   erx_cfg i_cfg (.rx_lclk_div4, .reset, .mi(mi), .mmu_dout, .dma_dout,
                  .mi_dout, .rx_enable, .mmu_enable);

   erx_protocol i_protocol (.rx_lclk_div4, .reset, .rx_enable, .rx_frame_par,
                            .rx_data_par, .erx_access, .erx_packet);

   erx_mmu i_mmu (.rx_lclk_div4, .reset, .mmu_enable, .mi(mi),
                  .in_access(erx_access), .in_packet(erx_packet),
                  .out_access(emmu_access), .out_packet(emmu_packet),
                  .mi_dout(mmu_dout));

   erx_dma i_dma (.rx_lclk_div4, .reset, .mi(mi), .dma_wait, .dma_access,
                  .dma_packet, .mi_dout(dma_dout));

   erx_disty i_disty (.rx_lclk_div4, .reset, .emmu_access, .emmu_packet,
                      .dma_access, .dma_packet, .wr_fifo_wait, .rd_fifo_wait,
                      .rr_fifo_wait, .dma_wait, .rxwr_fifo_access,
                      .rxrd_fifo_access, .rxrr_fifo_access, .fifo_packet,
                      .rx_wr_wait, .rx_rd_wait);

   // Writes
   erx_fifo rxwr_fifo (.rx_lclk_div4, .reset, .wr_en(rxwr_fifo_access),
                       .din(fifo_packet), .rd_wait(rxwr_wait), .access(rxwr_access),
                       .dout(rxwr_packet), .prog_full(wr_fifo_wait));

   // Read requests
   erx_fifo rxrd_fifo (.rx_lclk_div4, .reset, .wr_en(rxrd_fifo_access),
                       .din(fifo_packet), .rd_wait(rxrd_wait), .access(rxrd_access),
                       .dout(rxrd_packet), .prog_full(rd_fifo_wait));

   // Read responses
   erx_fifo rxrr_fifo (.rx_lclk_div4, .reset, .wr_en(rxrr_fifo_access),
                       .din(fifo_packet), .rd_wait(rxrr_wait), .access(rxrr_access),
                       .dout(rxrr_packet), .prog_full(rr_fifo_wait));

endmodule

`default_nettype wire

// ==== erx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module erx_tb
   import erx_pkg::*;
();

   localparam int WAIT_LIMIT = 2000;   // Cycles before any wait gives up
   localparam int LINK_LAT   = 4;      // Second beat to queue output

   logic         rx_lclk_div4;
   logic         reset;
   logic [7:0]   rx_frame_par;
   logic [63:0]  rx_data_par;
   logic         rx_wr_wait, rx_rd_wait;
   logic         rxwr_access, rxrd_access, rxrr_access;
   logic [103:0] rxwr_packet, rxrd_packet, rxrr_packet;
   logic         rxwr_wait, rxrd_wait, rxrr_wait;
   logic         mi_en, mi_we;
   logic [19:0]  mi_addr;
   logic [31:0]  mi_din, mi_dout;

   integer seed;          // Stimulus stream
   integer wait_seed;     // Output wait stream
   int     wait_mode;     // 0 low, 1 random, 2 hold rxwr
   int     errors, checks, sent_cnt;
   int     tests, failed_tests, test_err_base;

   // Reference model state
   logic                 m_rx_en;
   logic                 m_mmu_en;
   logic [MMU_TAG_W-1:0] m_tbl [MMU_ENTRIES];
   packet_t              exp_wr[$], exp_rd[$], exp_rr[$], exp_dma[$];

   erx i_dut (.*);

   initial
   begin
      rx_lclk_div4 = 1'b0;
      forever #2 rx_lclk_div4 = ~rx_lclk_div4;   // 4 ns period
   end

   task automatic report_error(input string msg);
      errors++;
      $display("error at %0d ns: %s", $time, msg);
   endtask

   task automatic check_packet(input string name, input packet_t got, input packet_t want);
      checks++;
      if (got !== want)
      begin
         errors++;
         $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, want);
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] want);
      checks++;
      if (got !== want)
      begin
         errors++;
         $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, want);
      end
   endtask

   task automatic check_level(input string name, input logic got, input logic want);
      checks++;
      if (got !== want)
      begin
         errors++;
         $display("mismatch at %0d ns: %s got %b expected %b", $time, name, got, want);
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors != test_err_base)
         failed_tests++;
      $display("test %0d %-18s %s, %0d errors", tests, name,
               (errors == test_err_base) ? "ok" : "bad", errors - test_err_base);
      test_err_base = errors;
   endtask

   // Random packet, kind 0 plain write, 1 read request, 2 response write
   task automatic make_packet(input int kind, output packet_t p);
      logic [31:0] r;
      r = $random(seed);
      p.srcaddr = r;
      r = $random(seed);
      p.data = r;
      r = $random(seed);
      p.dstaddr = r;
      r = $random(seed);
      p.ctrlmode = r[3:0];
      p.datamode = r[5:4];
      p.spare    = 1'b0;
      p.write    = (kind != 1);
      if (kind == 2)
         p.dstaddr[31:20] = RESP_ID;
      else if (kind == 0 && p.dstaddr[31:20] == RESP_ID)
         p.dstaddr[31:20] = ~RESP_ID;   // Keep it off the response queue
   endtask

   // Translate, then route like the distributor
   task automatic expect_link(input packet_t p);
      packet_t e;
      e = p;
      if (m_mmu_en)
         e.dstaddr[31:20] = m_tbl[p.dstaddr[31:28]];
      if (!e.write)
         exp_rd.push_back(e);
      else if (e.dstaddr[31:20] == RESP_ID)
         exp_rr.push_back(e);
      else
         exp_wr.push_back(e);
   endtask

   task automatic wait_link_ready();
      int n;
      n = 0;
      while ((rx_wr_wait || rx_rd_wait) && n < WAIT_LIMIT)
      begin
         @(negedge rx_lclk_div4);
         n++;
      end
      if (rx_wr_wait || rx_rd_wait)
         report_error("timeout: link waits stayed high");
   endtask

   // Two framed beats and one idle cycle, starts and ends at a falling edge
   task automatic send_packet(input packet_t p);
      logic [31:0] fill;
      wait_link_ready();
      fill = $random(seed);   // Junk in the unused beat-0 bits
      @(posedge rx_lclk_div4);
      rx_frame_par <= 8'hff;
      rx_data_par  <= {p.ctrlmode, p.datamode, p.write, fill[24], p.dstaddr, fill[23:0]};
      @(posedge rx_lclk_div4);
      rx_data_par  <= {p.data, p.srcaddr};
      sent_cnt++;
      if (m_rx_en)
         expect_link(p);
      @(posedge rx_lclk_div4);
      rx_frame_par <= 8'h00;
      rx_data_par  <= 64'd0;
      @(negedge rx_lclk_div4);
   endtask

   task automatic send_random(input int count);
      packet_t     p;
      logic [31:0] r;
      for (int i = 0; i < count; i++)
      begin
         r = $random(seed);
         make_packet(int'(r % 3), p);
         send_packet(p);
      end
   endtask

   task automatic bus_write(input logic [19:0] addr, input logic [31:0] data);
      @(posedge rx_lclk_div4);
      mi_en   <= 1'b1;
      mi_we   <= 1'b1;
      mi_addr <= addr;
      mi_din  <= data;
      @(posedge rx_lclk_div4);
      mi_en   <= 1'b0;
      mi_we   <= 1'b0;
      @(negedge rx_lclk_div4);
   endtask

   // Read word is registered one cycle after the request
   task automatic bus_read(input logic [19:0] addr, output logic [31:0] data);
      @(posedge rx_lclk_div4);
      mi_en   <= 1'b1;
      mi_we   <= 1'b0;
      mi_addr <= addr;
      @(posedge rx_lclk_div4);
      mi_en   <= 1'b0;
      @(negedge rx_lclk_div4);
      data = mi_dout;
   endtask

   task automatic set_cfg(input logic rx_en, input logic mmu_en);
      bus_write(CFG_ADDR, {30'd0, mmu_en, rx_en});
      m_rx_en  = rx_en;
      m_mmu_en = mmu_en;
   endtask

   task automatic drain_queues();
      int n;
      n = 0;
      while ((exp_wr.size() + exp_rd.size() + exp_rr.size() + exp_dma.size()) != 0 &&
             n < WAIT_LIMIT)
      begin
         @(negedge rx_lclk_div4);
         n++;
      end
      if ((exp_wr.size() + exp_rd.size() + exp_rr.size() + exp_dma.size()) != 0)
         report_error($sformatf("timeout: %0d write, %0d read, %0d response, %0d dma lost",
                      exp_wr.size(), exp_rd.size(), exp_rr.size(), exp_dma.size()));
   endtask

   task automatic idle_cycles(input int count);
      for (int i = 0; i < count; i++)
         @(negedge rx_lclk_div4);
   endtask

   // Output side waits, changed on the rising edge
   task automatic drive_waits();
      logic [31:0] r;
      forever
      begin
         @(posedge rx_lclk_div4);
         r = $random(wait_seed);
         case (wait_mode)
            1:
            begin
               rxwr_wait <= (r[1:0] == 2'b00);   // Busy about a quarter of the time
               rxrd_wait <= (r[3:2] == 2'b00);
               rxrr_wait <= (r[5:4] == 2'b00);
            end
            2:
            begin
               rxwr_wait <= 1'b1;
               rxrd_wait <= 1'b0;
               rxrr_wait <= 1'b0;
            end
            default:
            begin
               rxwr_wait <= 1'b0;
               rxrd_wait <= 1'b0;
               rxrr_wait <= 1'b0;
            end
         endcase
      end
   endtask

   // Link and DMA writes interleave by arbitration, each stream stays in order
   task automatic take_write(input packet_t got);
      if (exp_dma.size() != 0 && (exp_wr.size() == 0 || got !== exp_wr[0]))
         check_packet("rxwr_packet", got, exp_dma.pop_front());
      else if (exp_wr.size() != 0)
         check_packet("rxwr_packet", got, exp_wr.pop_front());
      else
         report_error($sformatf("unexpected packet on rxwr: %h", got));
   endtask

   // Pops happen at the next rising edge, so sample on the falling one
   task automatic watch_outputs();
      forever
      begin
         @(negedge rx_lclk_div4);
         if (!reset && rxwr_access && !rxwr_wait)
            take_write(rxwr_packet);
         if (!reset && rxrd_access && !rxrd_wait)
         begin
            if (exp_rd.size() == 0)
               report_error($sformatf("unexpected packet on rxrd: %h", rxrd_packet));
            else
               check_packet("rxrd_packet", rxrd_packet, exp_rd.pop_front());
         end
         if (!reset && rxrr_access && !rxrr_wait)
         begin
            if (exp_rr.size() == 0)
               report_error($sformatf("unexpected packet on rxrr: %h", rxrr_packet));
            else
               check_packet("rxrr_packet", rxrr_packet, exp_rr.pop_front());
         end
      end
   endtask

   initial
   begin
      logic [31:0] r;
      logic [31:0] word;
      logic [31:0] dma_dst;
      logic [31:0] dma_data;
      packet_t     p;
      int          dma_n;
      int          n;

      seed      = 32'hedf3;
      wait_seed = $random(seed);
      wait_mode = 0;
      errors = 0;
      checks = 0;
      sent_cnt = 0;
      tests = 0;
      failed_tests = 0;
      test_err_base = 0;
      m_rx_en  = 1'b0;
      m_mmu_en = 1'b0;
      for (int i = 0; i < MMU_ENTRIES; i++)
         m_tbl[i] = '0;

      reset        <= 1'b1;
      rx_frame_par <= 8'h00;
      rx_data_par  <= 64'd0;
      rxwr_wait    <= 1'b0;
      rxrd_wait    <= 1'b0;
      rxrr_wait    <= 1'b0;
      mi_en        <= 1'b0;
      mi_we        <= 1'b0;
      mi_addr      <= 20'd0;
      mi_din       <= 32'd0;

      fork
         drive_waits();
         watch_outputs();
      join_none

      repeat (2) @(posedge rx_lclk_div4);
      reset <= 1'b0;
      @(negedge rx_lclk_div4);

      // Everything idle and disabled out of reset
      check_level("rxwr_access", rxwr_access, 1'b0);
      check_level("rxrd_access", rxrd_access, 1'b0);
      check_level("rxrr_access", rxrr_access, 1'b0);
      check_level("rx_wr_wait", rx_wr_wait, 1'b0);
      check_level("rx_rd_wait", rx_rd_wait, 1'b0);
      bus_read(CFG_ADDR, word);
      check_word("mi_dout", word, 32'd0);
      end_test("reset values");

      set_cfg(1'b1, 1'b0);
      wait_mode = 1;
      for (int i = 0; i < 40; i++)
      begin
         make_packet(0, p);
         send_packet(p);
      end
      drain_queues();
      end_test("write path");

      send_random(45);   // Reads, responses and writes mixed
      drain_queues();
      end_test("mixed routing");

      for (int i = 0; i < MMU_ENTRIES; i++)
      begin
         r = $random(seed);
         m_tbl[i] = r[11:0];
         bus_write(MMU_BASE_ADDR + 20'(4 * i), r);   // Upper bits dropped
      end
      for (int i = 0; i < MMU_ENTRIES; i++)
      begin
         bus_read(MMU_BASE_ADDR + 20'(4 * i), word);
         check_word("mi_dout", word, {20'd0, m_tbl[i]});
      end
      set_cfg(1'b1, 1'b1);
      bus_read(CFG_ADDR, word);
      check_word("mi_dout", word, 32'd3);
      send_random(48);
      drain_queues();
      end_test("translation table");

      // Link off, the monitor flags anything that comes out
      set_cfg(1'b0, 1'b0);
      send_random(10);
      idle_cycles(LINK_LAT + 2);
      check_level("rxwr_access", rxwr_access, 1'b0);
      check_level("rxrd_access", rxrd_access, 1'b0);
      check_level("rxrr_access", rxrr_access, 1'b0);
      end_test("link disabled");

      set_cfg(1'b1, 1'b0);
      r = $random(seed);
      dma_dst = {r[31:20], 8'h00, r[11:2], 2'b00};   // No carry into the tag
      if (dma_dst[31:20] == RESP_ID)
         dma_dst[31:20] = ~RESP_ID;
      dma_data = $random(seed);
      r = $random(seed);
      dma_n = 8 + int'(r[2:0]);
      for (int i = 0; i < dma_n; i++)
      begin
         p          = '0;
         p.write    = 1'b1;
         p.datamode = DM_WORD;
         p.dstaddr  = dma_dst + 32'(4 * i);
         p.data     = dma_data + 32'(i);
         exp_dma.push_back(p);
      end
      bus_write(DMA_DST_ADDR, dma_dst);
      bus_write(DMA_DATA_ADDR, dma_data);
      bus_write(DMA_COUNT_ADDR, 32'(dma_n));   // Burst starts here
      send_random(20);
      drain_queues();
      bus_read(DMA_COUNT_ADDR, word);
      check_word("mi_dout", word, 32'd0);
      end_test("dma burst");

      // Write queue held, link must back off at the wait level
      wait_mode = 2;
      sent_cnt  = 0;
      fork
         begin
            for (int i = 0; i < FIFO_WAIT_LEVEL + 4; i++)
            begin
               make_packet(0, p);
               send_packet(p);
            end
         end
         begin
            n = 0;
            while (!rx_wr_wait && n < WAIT_LIMIT)
            begin
               @(negedge rx_lclk_div4);
               n++;
            end
            if (!rx_wr_wait)
               report_error("rx_wr_wait never rose while rxwr_wait was held");
            else
            begin
               checks++;
               // One more packet is already on the link when the level is reached
               if (sent_cnt < FIFO_WAIT_LEVEL || sent_cnt > FIFO_WAIT_LEVEL + 1)
                  report_error($sformatf("rx_wr_wait rose after %0d packets", sent_cnt));
               check_level("rxwr_access", rxwr_access, 1'b1);
            end
            idle_cycles(20);
            check_level("rx_wr_wait", rx_wr_wait, 1'b1);   // Still nothing popped
            wait_mode = 0;
         end
      join
      drain_queues();
      check_level("rx_wr_wait", rx_wr_wait, 1'b0);
      end_test("back-pressure");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests, failed_tests, checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
erx_pkg.sv
erx_ifs.sv
erx_cfg.sv
erx_protocol.sv
erx_mmu.sv
erx_dma.sv
erx_disty.sv
erx_fifo.sv
erx.sv
erx_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the erx testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module erx_tb -f vlog.f -o erx_sim

out=$(./obj_dir/erx_sim)
echo "$out"

# Exit status follows the testbench verdict
echo "$out" | grep -q "ALL CHECKS PASSED"
